/* Bender.yml */
package:
  name: soc_fabric

sources:
  - hw/soc_pkg.sv
  - hw/wb_master_bridge.sv
  - hw/wb_intercon.sv
  - hw/data_mem.sv
  - hw/gpio_ctrl.sv
  - hw/pwm_timer.sv
  - hw/soc_top.sv
  - target: simulation
    files:
      - sim/soc_checker.sv
      - sim/tb_soc.sv

/* hw/data_mem.sv */
`timescale 1ns/1ps

module data_mem import soc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  wb_m2s_t wb_i,
    output wb_s2m_t wb_o
);

    logic [XLEN-1:0]    mem [DMEM_WORDS];
    logic [XLEN-1:0]    rdata_q;
    logic               ack_q;
    logic               access;
    logic [DMEM_AW-1:0] idx;

    // New strobe only, so the write lands once per cycle
    assign access = wb_i.cyc && wb_i.stb && !ack_q;
    assign idx    = wb_i.adr[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_i.we) begin
                for (int b = 0; b < XLEN / 8; b++) begin
                    if (wb_i.sel[b]) begin
                        mem[idx][8*b +: 8] <= wb_i.dat[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign wb_o = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

/* hw/gpio_ctrl.sv */
`timescale 1ns/1ps

module gpio_ctrl import soc_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  wb_m2s_t             wb_i,
    output wb_s2m_t             wb_o,
    input  logic                pwm_i,
    input  logic [NUM_GPIO-1:0] gpio_i,
    output logic [NUM_GPIO-1:0] gpio_o,
    output logic [NUM_GPIO-1:0] gpio_en_o
);

    logic [NUM_GPIO-1:0] out_q;
    logic [NUM_GPIO-1:0] en_q;
    logic                sel_q;
    logic [NUM_GPIO-1:0] sync1_q;
    logic [NUM_GPIO-1:0] sync2_q;
    logic [XLEN-1:0]     rdata_q;
    logic                ack_q;
    logic                access;
    logic                wr;
    logic [4:0]          ofs;

    assign access = wb_i.cyc && wb_i.stb && !ack_q;
    assign wr     = access && wb_i.we;
    assign ofs    = wb_i.adr[4:0];

    // Two-flop input synchroniser, second stage is the input register
    always_ff @(posedge clk) begin
        sync1_q <= gpio_i;
        sync2_q <= sync1_q;
    end

    // ==========================================================
    // Registers
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_q <= '0;
            en_q  <= '0;
            sel_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            for (int b = 0; b < NUM_GPIO / 8; b++) begin
                if (wr && wb_i.sel[b] && ofs == GPIO_OUT_OFS) begin
                    out_q[8*b +: 8] <= wb_i.dat[8*b +: 8];
                end
                if (wr && wb_i.sel[b] && ofs == GPIO_EN_OFS) begin
                    en_q[8*b +: 8] <= wb_i.dat[8*b +: 8];
                end
            end
            if (wr && wb_i.sel[0] && ofs == GPIO_SEL_OFS) begin
                sel_q <= wb_i.dat[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (ofs)
                GPIO_IN_OFS:  rdata_q <= XLEN'(sync2_q);
                GPIO_OUT_OFS: rdata_q <= XLEN'(out_q);
                GPIO_EN_OFS:  rdata_q <= XLEN'(en_q);
                GPIO_SEL_OFS: rdata_q <= XLEN'(sel_q);
                default:      rdata_q <= '0;
            endcase
        end
    end

    assign wb_o = '{dat: rdata_q, ack: ack_q, err: 1'b0};

    // ==========================================================
    // Pad mux
    // ==========================================================
    always_comb begin
        gpio_o    = out_q;
        gpio_en_o = en_q;
        if (sel_q) begin
            gpio_o[PWM_PIN]    = pwm_i;
            gpio_en_o[PWM_PIN] = 1'b1;
        end
    end

endmodule

/* hw/pwm_timer.sv */
`timescale 1ns/1ps

module pwm_timer import soc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  wb_m2s_t wb_i,
    output wb_s2m_t wb_o,
    output logic    pwm_o
);

    logic [XLEN-1:0] period_q;
    logic [XLEN-1:0] duty_q;
    logic            en_q;
    logic [XLEN-1:0] cnt_q;
    logic [XLEN-1:0] rdata_q;
    logic            ack_q;
    logic            access;
    logic            wr;

    assign access = wb_i.cyc && wb_i.stb && !ack_q;
    assign wr     = access && wb_i.we;

    // Whole-word register writes
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            period_q <= '0;
            duty_q   <= '0;
            en_q     <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= access;
            if (wr && wb_i.adr[4:0] == PWM_PERIOD_OFS) period_q <= wb_i.dat;
            if (wr && wb_i.adr[4:0] == PWM_DUTY_OFS)   duty_q   <= wb_i.dat;
            if (wr && wb_i.adr[4:0] == PWM_CTRL_OFS)   en_q     <= wb_i.dat[0];
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (wb_i.adr[4:0])
                PWM_PERIOD_OFS: rdata_q <= period_q;
                PWM_DUTY_OFS:   rdata_q <= duty_q;
                PWM_CTRL_OFS:   rdata_q <= XLEN'(en_q);
                default:        rdata_q <= '0;
            endcase
        end
    end

    // Counter runs 0 .. period-1, held at zero while disabled
    always_ff @(posedge clk) begin
        if (!rst_n_i || !en_q) begin
            cnt_q <= '0;
        end else if (cnt_q + 1'b1 >= period_q) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign pwm_o = en_q && (cnt_q < duty_q);
    assign wb_o  = '{dat: rdata_q, ack: ack_q, err: 1'b0};

endmodule

/* hw/soc_pkg.sv */
package soc_pkg;

    // ==========================================================
    // Widths and address map
    // ==========================================================
    localparam int XLEN       = 32;
    localparam int NUM_GPIO   = 32;
    localparam int DMEM_WORDS = 2048;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] DMEM_BASE    = 32'h0000_0000;
    localparam logic [XLEN-1:0] DMEM_BYTES   = DMEM_WORDS * 4;
    localparam logic [XLEN-1:0] GPIO_BASE    = 32'h2000_0000;
    localparam logic [XLEN-1:0] PWM_BASE     = 32'h2000_0100;
    localparam logic [XLEN-1:0] PERIPH_BYTES = 32;

    // Pad shared between GPIO and PWM
    localparam int PWM_PIN = 0;

    // Register offsets inside a peripheral window
    localparam logic [4:0] GPIO_IN_OFS    = 5'h00;
    localparam logic [4:0] GPIO_OUT_OFS   = 5'h04;
    localparam logic [4:0] GPIO_EN_OFS    = 5'h08;
    localparam logic [4:0] GPIO_SEL_OFS   = 5'h0C;
    localparam logic [4:0] PWM_PERIOD_OFS = 5'h00;
    localparam logic [4:0] PWM_DUTY_OFS   = 5'h04;
    localparam logic [4:0] PWM_CTRL_OFS   = 5'h08;

    // ==========================================================
    // Processor port and Wishbone types
    // ==========================================================
    // Load/store size, RISC-V funct3 encoding
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101
    } mem_op_e;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            write;
        logic            read;
        mem_op_e         op;
    } proc_req_t;

    typedef struct packed {
        logic [XLEN-1:0] rdata;
        logic            ack;
        logic            err;
    } proc_rsp_t;

    typedef struct packed {
        logic [XLEN-1:0] adr;
        logic [XLEN-1:0] dat;
        logic [3:0]      sel;
        logic            we;
        logic            cyc;
        logic            stb;
    } wb_m2s_t;

    typedef struct packed {
        logic [XLEN-1:0] dat;
        logic            ack;
        logic            err;
    } wb_s2m_t;

endpackage

/* hw/soc_top.sv */
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  proc_req_t           proc_req_i,
    output proc_rsp_t           proc_rsp_o,
    output logic                stall_o,
    input  logic [NUM_GPIO-1:0] gpio_i,
    output logic [NUM_GPIO-1:0] gpio_o,
    output logic [NUM_GPIO-1:0] gpio_en_o
);

    wb_m2s_t bus_m2s;
    wb_s2m_t bus_s2m;
    wb_m2s_t dmem_m2s;
    wb_s2m_t dmem_s2m;
    wb_m2s_t gpio_m2s;
    wb_s2m_t gpio_s2m;
    wb_m2s_t pwm_m2s;
    wb_s2m_t pwm_s2m;
    logic    pwm_out;

    // ==========================================================
    // Master side
    // ==========================================================
    wb_master_bridge u_bridge (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (proc_req_i),
        .rsp_o   (proc_rsp_o),
        .stall_o (stall_o),
        .wb_o    (bus_m2s),
        .wb_i    (bus_s2m)
    );

    wb_intercon u_intercon (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .m_i     (bus_m2s),
        .m_o     (bus_s2m),
        .dmem_o  (dmem_m2s),
        .gpio_o  (gpio_m2s),
        .pwm_o   (pwm_m2s),
        .dmem_i  (dmem_s2m),
        .gpio_i  (gpio_s2m),
        .pwm_i   (pwm_s2m)
    );

    // ==========================================================
    // Slaves
    // ==========================================================
    data_mem u_dmem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (dmem_m2s),
        .wb_o    (dmem_s2m)
    );

    gpio_ctrl u_gpio (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .wb_i      (gpio_m2s),
        .wb_o      (gpio_s2m),
        .pwm_i     (pwm_out),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_en_o (gpio_en_o)
    );

    // PWM reaches the pad only through the GPIO pin select
    pwm_timer u_pwm (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (pwm_m2s),
        .wb_o    (pwm_s2m),
        .pwm_o   (pwm_out)
    );

endmodule

/* hw/wb_intercon.sv */
`timescale 1ns/1ps

module wb_intercon import soc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  wb_m2s_t m_i,
    output wb_s2m_t m_o,
    output wb_m2s_t dmem_o,
    output wb_m2s_t gpio_o,
    output wb_m2s_t pwm_o,
    input  wb_s2m_t dmem_i,
    input  wb_s2m_t gpio_i,
    input  wb_s2m_t pwm_i
);

    logic dmem_hit;
    logic gpio_hit;
    logic pwm_hit;
    logic err_q;

    function automatic logic in_window(input logic [XLEN-1:0] adr,
                                       input logic [XLEN-1:0] base,
                                       input logic [XLEN-1:0] bytes);
        return (adr & ~(bytes - 1'b1)) == base;
    endfunction

    // Strobe reaches a slave only when its window matches
    function automatic wb_m2s_t gate(input wb_m2s_t m, input logic hit);
        wb_m2s_t g;
        g     = m;
        g.cyc = m.cyc & hit;
        g.stb = m.stb & hit;
        return g;
    endfunction

    assign dmem_hit = in_window(m_i.adr, DMEM_BASE, DMEM_BYTES);
    assign gpio_hit = in_window(m_i.adr, GPIO_BASE, PERIPH_BYTES);
    assign pwm_hit  = in_window(m_i.adr, PWM_BASE, PERIPH_BYTES);

    assign dmem_o = gate(m_i, dmem_hit);
    assign gpio_o = gate(m_i, gpio_hit);
    assign pwm_o  = gate(m_i, pwm_hit);

    // Unmapped access, answered like a slave one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= m_i.cyc && m_i.stb && !(dmem_hit || gpio_hit || pwm_hit) && !err_q;
        end
    end

    always_comb begin
        if (dmem_hit) begin
            m_o = dmem_i;
        end else if (gpio_hit) begin
            m_o = gpio_i;
        end else if (pwm_hit) begin
            m_o = pwm_i;
        end else begin
            m_o = '{dat: '0, ack: 1'b0, err: err_q};
        end
    end

endmodule

/* hw/wb_master_bridge.sv */
`timescale 1ns/1ps

module wb_master_bridge import soc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  proc_req_t req_i,
    output proc_rsp_t rsp_o,
    output logic      stall_o,
    output wb_m2s_t   wb_o,
    input  wb_s2m_t   wb_i
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e          state_q;
    logic [XLEN-1:0] adr_q;
    logic [XLEN-1:0] dat_q;
    logic [3:0]      sel_q;
    logic            we_q;
    mem_op_e         op_q;
    logic [1:0]      ofs_q;
    logic [3:0]      sel_d;
    logic [XLEN-1:0] dat_d;
    logic [1:0]      ofs_d;
    logic [XLEN-1:0] lane;
    logic [XLEN-1:0] rdata_d;
    logic [XLEN-1:0] rsp_data_q;
    logic            rsp_ack_q;
    logic            rsp_err_q;
    logic            start;
    logic            done;

    assign start = (state_q == ST_IDLE) && (req_i.read || req_i.write);
    assign done  = (state_q == ST_BUSY) && (wb_i.ack || wb_i.err);

    // Lane select and store data replication
    always_comb begin
        case (req_i.op)
            MEM_B, MEM_BU: begin
                ofs_d = req_i.addr[1:0];
                sel_d = 4'b0001 << ofs_d;
                dat_d = {4{req_i.wdata[7:0]}};
            end
            MEM_H, MEM_HU: begin
                ofs_d = {req_i.addr[1], 1'b0};
                sel_d = 4'b0011 << ofs_d;
                dat_d = {2{req_i.wdata[15:0]}};
            end
            default: begin
                ofs_d = 2'b00;
                sel_d = 4'b1111;
                dat_d = req_i.wdata;
            end
        endcase
    end

    // Align the returned lane, then extend
    always_comb begin
        lane = wb_i.dat >> {ofs_q, 3'b000};
        case (op_q)
            MEM_B:   rdata_d = {{(XLEN-8){lane[7]}}, lane[7:0]};
            MEM_BU:  rdata_d = {{(XLEN-8){1'b0}}, lane[7:0]};
            MEM_H:   rdata_d = {{(XLEN-16){lane[15]}}, lane[15:0]};
            MEM_HU:  rdata_d = {{(XLEN-16){1'b0}}, lane[15:0]};
            default: rdata_d = lane;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            rsp_ack_q <= 1'b0;
            rsp_err_q <= 1'b0;
        end else begin
            rsp_ack_q <= done && wb_i.ack;
            rsp_err_q <= done && wb_i.err && !wb_i.ack;
            if (start) begin
                state_q <= ST_BUSY;
            end else if (done) begin
                state_q <= ST_IDLE;
            end
        end
    end

    // Access payload, captured with the request
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= {req_i.addr[XLEN-1:2], 2'b00};
            dat_q <= dat_d;
            sel_q <= sel_d;
            we_q  <= req_i.write;
            op_q  <= req_i.op;
            ofs_q <= ofs_d;
        end
        if (done) begin
            rsp_data_q <= wb_i.ack ? rdata_d : '0;
        end
    end

    // One cycle stays open for the whole access
    assign stall_o = (state_q == ST_BUSY);

    assign wb_o = '{adr: adr_q, dat: dat_q, sel: sel_q, we: we_q,
                    cyc: stall_o, stb: stall_o};

    assign rsp_o = '{rdata: rsp_data_q, ack: rsp_ack_q, err: rsp_err_q};

endmodule

/* sim/soc_checker.sv */
`timescale 1ns/1ps

module soc_checker import soc_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  proc_rsp_t           proc_rsp_i,
    input  logic                stall_i,
    input  logic [NUM_GPIO-1:0] gpio_i,
    input  logic [NUM_GPIO-1:0] gpio_en_i
);

    int err_cnt = 0;
    int chk_cnt = 0;
    int rst_edges = 0;

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Response pulse, ack and err are exclusive
    task automatic check_rsp(input logic exp_err, input logic use_data,
                             input logic [XLEN-1:0] exp_data);
        check_value("proc_rsp_o.ack", XLEN'(!exp_err), XLEN'(proc_rsp_i.ack));
        check_value("proc_rsp_o.err", XLEN'(exp_err), XLEN'(proc_rsp_i.err));
        if (use_data) begin
            check_value("proc_rsp_o.rdata", exp_data, proc_rsp_i.rdata);
        end
    endtask

    task automatic check_stall(input logic exp);
        check_value("stall_o", XLEN'(exp), XLEN'(stall_i));
    endtask

    task automatic check_pads(input logic [NUM_GPIO-1:0] exp_o,
                              input logic [NUM_GPIO-1:0] exp_en);
        check_value("gpio_o", XLEN'(exp_o), XLEN'(gpio_i));
        check_value("gpio_en_o", XLEN'(exp_en), XLEN'(gpio_en_i));
    endtask

    always @(posedge clk) begin
        if (!rst_n_i) begin
            rst_edges <= rst_edges + 1;
        end
    end

    // Idle outputs while reset is held, once the first edge has cleared the flops
    always @(negedge clk) begin
        if (!rst_n_i && rst_edges >= 1) begin
            check_stall(1'b0);
            check_value("proc_rsp_o.ack", '0, XLEN'(proc_rsp_i.ack));
            check_value("proc_rsp_o.err", '0, XLEN'(proc_rsp_i.err));
            check_pads('0, '0);
        end
    end

endmodule

/* sim/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc import soc_pkg::*; ();

    localparam int N_INIT  = 16;
    localparam int N_DMEM  = 200;
    localparam int N_GPIO  = 16;
    localparam int N_GIN   = 8;
    localparam int N_UNMAP = 8;
    localparam int N_ACC   = N_INIT + N_DMEM + N_GPIO * 4 + N_GIN + N_UNMAP * 3 + 6;
    // Two windows of up to 32 cycles, a skip and some settling
    localparam int PWM_WIN = 100;
    localparam int LIMIT   = N_ACC * 4 + PWM_WIN + 100;

    logic                clk;
    logic                rst_n;
    proc_req_t           req;
    proc_rsp_t           rsp;
    logic                stall;
    logic [NUM_GPIO-1:0] gpio_in;
    logic [NUM_GPIO-1:0] gpio_out;
    logic [NUM_GPIO-1:0] gpio_en;
    logic [31:0]         lfsr_q = 32'he1ce;
    logic [XLEN-1:0]     mdl_mem [N_INIT];
    logic [XLEN-1:0]     gout;
    logic [XLEN-1:0]     gen;
    int                  cycles = 0;

    soc_top DUT (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .proc_req_i (req),
        .proc_rsp_o (rsp),
        .stall_o    (stall),
        .gpio_i     (gpio_in),
        .gpio_o     (gpio_out),
        .gpio_en_o  (gpio_en)
    );

    soc_checker u_chk (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .proc_rsp_i (rsp),
        .stall_i    (stall),
        .gpio_i     (gpio_out),
        .gpio_en_i  (gpio_en)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==========================================================
    // Random source and model helpers
    // ==========================================================
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic mem_op_e pick_op(input logic [2:0] r, input logic store);
        mem_op_e ops [5];
        ops = '{MEM_B, MEM_H, MEM_W, MEM_BU, MEM_HU};
        return store ? ops[r % 3] : ops[r % 5];
    endfunction

    function automatic logic [1:0] align_ofs(input mem_op_e op, input logic [1:0] r);
        if (op == MEM_B || op == MEM_BU) return r;
        if (op == MEM_H || op == MEM_HU) return {r[1], 1'b0};
        return 2'b00;
    endfunction

    function automatic logic [XLEN-1:0] apply_store(input logic [XLEN-1:0] old,
            input mem_op_e op, input logic [1:0] ofs, input logic [XLEN-1:0] data);
        logic [XLEN-1:0] w;
        w = old;
        if (op == MEM_B) w[8*ofs +: 8] = data[7:0];
        else if (op == MEM_H) w[8*ofs +: 16] = data[15:0];
        else w = data;
        return w;
    endfunction

    function automatic logic [XLEN-1:0] load_value(input logic [XLEN-1:0] word,
            input mem_op_e op, input logic [1:0] ofs);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*ofs +: 8];
        h = word[8*ofs +: 16];
        case (op)
            MEM_B:   return {{24{b[7]}}, b};
            MEM_BU:  return {24'h0, b};
            MEM_H:   return {{16{h[15]}}, h};
            MEM_HU:  return {16'h0, h};
            default: return word;
        endcase
    endfunction

    // One request pulse, then wait for the response pulse
    task automatic bus_access(input logic wr, input mem_op_e op, input logic [XLEN-1:0] addr,
            input logic [XLEN-1:0] wdata, input logic use_data,
            input logic [XLEN-1:0] exp_data, input logic exp_err);
        int edges;
        @(posedge clk);
        req <= '{addr: addr, wdata: wdata, write: wr, read: !wr, op: op};
        @(posedge clk);
        req.write <= 1'b0;
        req.read  <= 1'b0;
        edges = 0;
        @(negedge clk);
        while (!(rsp.ack || rsp.err)) begin
            u_chk.check_stall(1'b1);
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        u_chk.check_value("response latency", 2, edges);
        u_chk.check_stall(1'b0);
        u_chk.check_rsp(exp_err, use_data, exp_data);
    endtask

    // ==========================================================
    // Stimulus
    // ==========================================================
    initial begin
        logic            wr;
        mem_op_e         op;
        logic [1:0]      ofs;
        logic [3:0]      idx;
        logic [XLEN-1:0] d;
        logic [XLEN-1:0] a;
        int              period;
        int              duty;
        int              highs;
        req     = '0;
        gpio_in = '0;
        rst_n   = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        u_chk.check_stall(1'b0);
        u_chk.check_pads('0, '0);

        // Known contents for the test region
        for (int i = 0; i < N_INIT; i++) begin
            d          = rand_bits(32);
            mdl_mem[i] = d;
            bus_access(1'b1, MEM_W, DMEM_BASE + 4 * i, d, 1'b0, '0, 1'b0);
        end
        for (int i = 0; i < N_DMEM; i++) begin
            wr  = rand_bits(1);
            op  = pick_op(rand_bits(3), wr);
            ofs = align_ofs(op, rand_bits(2));
            idx = rand_bits(4);
            d   = rand_bits(32);
            a   = DMEM_BASE + {idx, ofs};
            if (wr) begin
                mdl_mem[idx] = apply_store(mdl_mem[idx], op, ofs, d);
                bus_access(1'b1, op, a, d, 1'b0, '0, 1'b0);
            end else begin
                bus_access(1'b0, op, a, '0, 1'b1, load_value(mdl_mem[idx], op, ofs), 1'b0);
            end
        end

        // GPIO output and enable registers, partial writes included
        gout = '0;
        gen  = '0;
        for (int i = 0; i < N_GPIO; i++) begin
            op   = pick_op(rand_bits(3), 1'b1);
            ofs  = align_ofs(op, rand_bits(2));
            d    = rand_bits(32);
            gout = apply_store(gout, op, ofs, d);
            bus_access(1'b1, op, GPIO_BASE + GPIO_OUT_OFS + ofs, d, 1'b0, '0, 1'b0);
            op  = pick_op(rand_bits(3), 1'b1);
            ofs = align_ofs(op, rand_bits(2));
            d   = rand_bits(32);
            gen = apply_store(gen, op, ofs, d);
            bus_access(1'b1, op, GPIO_BASE + GPIO_EN_OFS + ofs, d, 1'b0, '0, 1'b0);
            u_chk.check_pads(gout, gen);
            bus_access(1'b0, MEM_W, GPIO_BASE + GPIO_OUT_OFS, '0, 1'b1, gout, 1'b0);
            bus_access(1'b0, MEM_W, GPIO_BASE + GPIO_EN_OFS, '0, 1'b1, gen, 1'b0);
        end

        for (int i = 0; i < N_GIN; i++) begin
            d = rand_bits(32);
            @(posedge clk);
            gpio_in <= d;
            repeat (4) @(posedge clk);
            bus_access(1'b0, MEM_W, GPIO_BASE + GPIO_IN_OFS, '0, 1'b1, d, 1'b0);
        end

        // Unmapped window, low bits alias a word of the test region
        for (int i = 0; i < N_UNMAP; i++) begin
            idx = rand_bits(4);
            a   = 32'h4000_0000 | (rand_bits(17) << 13) | {idx, 2'b00};
            bus_access(1'b1, MEM_W, a, rand_bits(32), 1'b0, '0, 1'b1);
            bus_access(1'b0, MEM_W, a, '0, 1'b0, '0, 1'b1);
            bus_access(1'b0, MEM_W, DMEM_BASE + 4 * idx, '0, 1'b1, mdl_mem[idx], 1'b0);
        end

        // ==========================================================
        // PWM through the pin select
        // ==========================================================
        // Shared pad starts disabled so the forced enable shows
        gen[PWM_PIN] = 1'b0;
        bus_access(1'b1, MEM_W, GPIO_BASE + GPIO_EN_OFS, gen, 1'b0, '0, 1'b0);
        period = 8 + rand_bits(5) % 25;
        duty   = 1 + rand_bits(5) % (period - 1);
        bus_access(1'b1, MEM_W, PWM_BASE + PWM_PERIOD_OFS, period, 1'b0, '0, 1'b0);
        bus_access(1'b1, MEM_W, PWM_BASE + PWM_DUTY_OFS, duty, 1'b0, '0, 1'b0);
        bus_access(1'b1, MEM_W, PWM_BASE + PWM_CTRL_OFS, 32'h1, 1'b0, '0, 1'b0);
        bus_access(1'b1, MEM_W, GPIO_BASE + GPIO_SEL_OFS, 32'h1, 1'b0, '0, 1'b0);
        u_chk.check_value("gpio_en_o[PWM_PIN]", 1, gpio_en[PWM_PIN]);
        for (int w = 0; w < 2; w++) begin
            highs = 0;
            for (int c = 0; c < period; c++) begin
                @(negedge clk);
                highs += gpio_out[PWM_PIN];
            end
            u_chk.check_value("gpio_o[PWM_PIN] high cycles", duty, highs);
            repeat (rand_bits(4)) @(negedge clk);
        end
        bus_access(1'b1, MEM_W, GPIO_BASE + GPIO_SEL_OFS, 32'h0, 1'b0, '0, 1'b0);
        u_chk.check_pads(gout, gen);

        $display("Errors: %0d mismatches in %0d checks", u_chk.err_cnt, u_chk.chk_cnt);
        if (u_chk.err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("Errors: %0d mismatches in %0d checks", u_chk.err_cnt, u_chk.chk_cnt);
        $display("Test failed");
        $finish;
    end

endmodule

/* src.f */
hw/soc_pkg.sv
hw/wb_master_bridge.sv
hw/wb_intercon.sv
hw/data_mem.sv
hw/gpio_ctrl.sv
hw/pwm_timer.sv
hw/soc_top.sv
sim/soc_checker.sv
sim/tb_soc.sv
